//--- Makefile
SIM = verilator
FLAGS = --binary --timing --assert -j 0
TOP = tbDodgeGame
FILELIST = sources.f
PASS = all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf obj_dir

//--- dodgeChecker.sv
`timescale 1ns/1ps
// Testbench checker that models the player, ammo and score rules and compares them with the view
module dodgeChecker import dodgePkg::*; (
	input  logic    CLK,
	input  logic    RESETEDGE,
	input  Buttons  buttons,
	input  GameView view,
	input  logic    checkPoint,
	input  logic    testEnd,
	input  int      testId,
	output int      checkCount,
	output int      errorCount
);
	LanePos expPos;
	AmmoBits expAmmo;
	Buttons lastButtons;
	Buttons pressed;
	GameView prevView;
	GameView olderView; // Two samples back
	BcdScore tickScore; // Score at the last tick sample
	LanePos shotLane;
	logic shotPending;
	logic overAtTick;
	int sinceReset;
	int testChecks;
	int testErrors;

	initial begin
		checkCount = 0;
		errorCount = 0;
		testChecks = 0;
		testErrors = 0;
	end

	function automatic LanePos clampedMove(LanePos pos, logic left, logic right);
		if (left && !right && pos != '0) return pos - 1'b1;
		if (right && !left && pos != LanePos'(LaneCount - 1)) return pos + 1'b1;
		return pos;
	endfunction

	function automatic AmmoBits shiftAmmo(AmmoBits ammo);
		if (ammo == '0) return ammo; // Empty stock stays empty
		return ammo << 1;
	endfunction

	function automatic BcdScore bcdIncrement(BcdScore score);
		int value;
		BcdScore result;
		value = 0;
		for (int d = DigitCount - 1; d >= 0; d--) value = value * 10 + int'(score[d]);
		if (value < 9999) value++; // Full score holds
		for (int d = 0; d < DigitCount; d++) begin
			result[d] = 4'(value % 10);
			value = value / 10;
		end
		return result;
	endfunction

	task automatic compare(input string name, input logic [63:0] got, input logic [63:0] want);
		testChecks++;
		checkCount++;
		if (got !== want) begin
			testErrors++;
			errorCount++;
			$display("ERROR %s got %0h expected %0h", name, got, want);
		end
	endtask

	task automatic confirm(input logic ok, input string what);
		testChecks++;
		checkCount++;
		if (!ok) begin
			testErrors++;
			errorCount++;
			$display("FAILED %s", what);
		end
	endtask

	always @(posedge CLK) begin
		if (!RESETEDGE) begin
			expPos = LanePos'(PlayerStart);
			expAmmo = '1;
			lastButtons = '0;
			shotPending = 1'b0;
			sinceReset = 0;
			if (checkPoint) begin // Reset state of every field
				compare("view.laneRows", 64'(view.laneRows), 64'h0);
				compare("view.playerPos", 64'(view.playerPos), 64'(PlayerStart));
				compare("view.ammo", 64'(view.ammo), 64'h1f);
				compare("view.score", 64'(view.score), 64'h0);
				compare("view.gameOver", 64'(view.gameOver), 64'h0);
			end
		end else begin
			sinceReset++;
			pressed = buttons & ~lastButtons; // Same samples as the DUT synchroniser
			lastButtons = buttons;
			expPos = clampedMove(expPos, pressed.left, pressed.right);
			if (pressed.fire) expAmmo = shiftAmmo(expAmmo);
			if (checkPoint) begin
				compare("view.playerPos", 64'(view.playerPos), 64'(expPos));
				compare("view.ammo", 64'(view.ammo), 64'(expAmmo));
			end
			if (shotPending) compare("view.laneRows[shot]", 64'(view.laneRows[shotLane]), 64'h0);
			shotPending = view.ammo != prevView.ammo && !view.gameOver; // Lane clears next edge
			shotLane = view.playerPos;
			if (sinceReset % 32 == 0) overAtTick = view.gameOver;
			if (sinceReset % 32 == 1) begin
				if (sinceReset > 1) compare("view.score", 64'(view.score),
					overAtTick ? 64'(tickScore) : 64'(bcdIncrement(tickScore)));
				for (int d = 0; d < DigitCount; d++) confirm(view.score[d] <= 4'd9,
					"score digit left the range 0 to 9");
				tickScore = view.score;
			end
			if (view.gameOver && !prevView.gameOver)
				confirm(olderView.laneRows[olderView.playerPos] >= RowPos'(CollideRow),
					"game over rose without an obstacle at the player two edges earlier");
			if (view.gameOver && prevView.gameOver) begin // Frozen field
				compare("view.laneRows", 64'(view.laneRows), 64'(prevView.laneRows));
				compare("view.score", 64'(view.score), 64'(prevView.score));
			end
		end
		olderView = prevView;
		prevView = view;
		if (testEnd) begin
			$display("test %0d done with %0d checks and %0d errors", testId, testChecks, testErrors);
			testChecks = 0;
			testErrors = 0;
		end
	end
endmodule

//--- dodgeGame.sv
`timescale 1ns/1ps
// Dodge game top that wires player, timer, lanes and score into one view
module dodgeGame import dodgePkg::*; (
	input  logic    CLK,
	input  logic    RESETEDGE,
	input  Buttons  buttons,
	output GameView view
);
	LanePos playerPos;
	AmmoBits ammo;
	logic fireStrobe;
	logic [LaneCount-1:0] stepStrobes;
	SpeedState [LaneCount-1:0] laneSpeeds;
	RowPos [LaneCount-1:0] laneRows;
	logic [LaneCount-1:0] collide;
	BcdScore score;
	logic gameOver;

	playerControl player (
		.CLK(CLK),
		.RESETEDGE(RESETEDGE),
		.buttons(buttons),
		.playerPos(playerPos),
		.ammo(ammo),
		.fireStrobe(fireStrobe)
	);

	laneTimer timer (
		.CLK(CLK),
		.RESETEDGE(RESETEDGE),
		.speeds(laneSpeeds),
		.stepStrobes(stepStrobes)
	);

	for (genvar i = 0; i < LaneCount; i++) begin : lanes
		obstacleLane #(.LaneIndex(i)) lane (
			.CLK(CLK),
			.RESETEDGE(RESETEDGE),
			.stepStrobe(stepStrobes[i]),
			.playerPos(playerPos),
			.fireStrobe(fireStrobe),
			.gameOver(gameOver),
			.row(laneRows[i]),
			.speed(laneSpeeds[i]),
			.collide(collide[i])
		);
	end

	scoreKeeper keeper (
		.CLK(CLK),
		.RESETEDGE(RESETEDGE),
		.collide(collide),
		.score(score),
		.gameOver(gameOver)
	);

	always_comb begin
		view = '0; // Spare bits read as zero
		view.laneRows = laneRows;
		view.playerPos = playerPos;
		view.ammo = ammo;
		view.score = score;
		view.gameOver = gameOver;
	end
endmodule

//--- dodgePkg.sv
// Field sizes, timing constants, lane speed table and shared types of the dodge game
package dodgePkg;
	localparam int LaneCount = 8;
	localparam int RowCount = 8;
	localparam int CollideRow = 6; // Rows 6 and 7 can hit the player
	localparam int StepBits = 6; // 64 cycle fall period
	localparam int ScoreBits = 5; // Score tick every 32 cycles
	localparam int DigitCount = 4;
	localparam int AmmoMax = 5;
	localparam int PlayerStart = 4;

	typedef logic [$clog2(LaneCount)-1:0] LanePos;
	typedef logic [$clog2(RowCount)-1:0] RowPos; // Row 0 is the top
	typedef logic [1:0] SpeedState; // 0 slow, 1 and 2 medium, 3 fast
	typedef logic [AmmoMax-1:0] AmmoBits; // Left-aligned thermometer
	typedef logic [DigitCount-1:0][3:0] BcdScore;

	typedef struct packed {
		logic left;
		logic right;
		logic fire;
	} Buttons;

	typedef struct packed {
		logic [14:0] spare; // Pads the view to 64 bits
		logic gameOver;
		BcdScore score;
		AmmoBits ammo;
		LanePos playerPos;
		RowPos [LaneCount-1:0] laneRows; // Lane 0 in the low bits
	} GameView;

	// Lanes 7 down to 0
	localparam SpeedState [LaneCount-1:0] LaneSpeedInit = {
		2'd3, 2'd3, 2'd1, 2'd2, 2'd2, 2'd0, 2'd1, 2'd0
	};
endpackage

//--- laneTimer.sv
`timescale 1ns/1ps
// Shared fall timer that strobes each lane at the trigger points of its speed state
module laneTimer import dodgePkg::*; (
	input  logic                      CLK,
	input  logic                      RESETEDGE,
	input  SpeedState [LaneCount-1:0] speeds,
	output logic [LaneCount-1:0]      stepStrobes
);
	logic [StepBits-1:0] stepCount;
	logic [LaneCount-1:0] trigger;
	logic atZero;
	logic atHalf;
	logic atQuarter;

	assign atZero = stepCount == '0;
	assign atHalf = stepCount == {1'b1, {(StepBits - 1){1'b0}}};
	// Quarter and three-quarter points
	assign atQuarter = stepCount[StepBits-2] && (stepCount[StepBits-3:0] == '0);

	always_comb begin
		for (int i = 0; i < LaneCount; i++) begin
			case (speeds[i])
				2'd0: trigger[i] = atZero; // Once per period
				2'd3: trigger[i] = atZero || atHalf || atQuarter;
				default: trigger[i] = atZero || atHalf;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (!RESETEDGE) begin
			stepCount <= '0;
			stepStrobes <= '0;
		end else begin
			stepCount <= stepCount + 1'b1; // Free running
			stepStrobes <= trigger;
		end
	end

	// Slow strobe lands right after the counter wraps, so once per period
	for (genvar i = 0; i < LaneCount; i++) begin : laneCheck
		slowLaneOnce: assert property (@(posedge CLK) disable iff (!RESETEDGE)
			$past(RESETEDGE) && $past(speeds[i]) == 2'd0 |->
			stepStrobes[i] == (stepCount == StepBits'(1)))
			else $error("slow lane %0d strobed off its period", i);
	end
endmodule

//--- obstacleLane.sv
`timescale 1ns/1ps
// One obstacle lane that falls, speeds up, clears on a shot and flags a hit on the player
module obstacleLane import dodgePkg::*; #(
	parameter int LaneIndex = 0
) (
	input  logic      CLK,
	input  logic      RESETEDGE,
	input  logic      stepStrobe,
	input  LanePos    playerPos,
	input  logic      fireStrobe,
	input  logic      gameOver,
	output RowPos     row,
	output SpeedState speed,
	output logic      collide
);
	logic playerHere;
	logic atBottom;

	assign playerHere = playerPos == LanePos'(LaneIndex);
	assign atBottom = row >= RowPos'(CollideRow);

	always_ff @(posedge CLK) begin
		if (!RESETEDGE) begin
			row <= '0;
			speed <= LaneSpeedInit[LaneIndex];
			collide <= 1'b0;
		end else begin
			collide <= 1'b0;
			if (!gameOver) begin // Frozen once the game ends
				if (fireStrobe && playerHere) begin
					row <= '0; // Shot wins over a step
				end else if (stepStrobe) begin
					if (playerHere && atBottom) begin
						collide <= 1'b1; // Hit, obstacle stays put
					end else begin
						row <= row + 1'b1; // Wraps 7 to 0
						if (row == RowPos'(CollideRow)) begin
							speed <= speed + 1'b1; // Passed the player unhit
						end
					end
				end
			end
		end
	end

	hitAtBottom: assert property (@(posedge CLK) disable iff (!RESETEDGE)
		collide |-> atBottom && $past(playerPos) == LanePos'(LaneIndex) && $past(stepStrobe))
		else $error("lane %0d collided away from the player row", LaneIndex);
endmodule

//--- playerControl.sv
`timescale 1ns/1ps
// Player input block with button sync, edge detect, lane position and ammunition
module playerControl import dodgePkg::*; (
	input  logic    CLK,
	input  logic    RESETEDGE,
	input  Buttons  buttons,
	output LanePos  playerPos,
	output AmmoBits ammo,
	output logic    fireStrobe
);
	Buttons syncFirst; // First synchroniser stage
	Buttons syncSecond;
	Buttons levelLast; // Synchronised level one cycle back
	Buttons pressEdge; // Registered rising edges
	logic shotOk;
	AmmoBits ammoGap;

	assign shotOk = pressEdge.fire && (ammo != '0);
	assign ammoGap = ~ammo + 1'b1; // Power of two for a clean thermometer

	always_ff @(posedge CLK) begin
		if (!RESETEDGE) begin
			syncFirst <= '0;
			syncSecond <= '0;
			levelLast <= '0;
			pressEdge <= '0;
		end else begin
			syncFirst <= buttons;
			syncSecond <= syncFirst;
			levelLast <= syncSecond;
			pressEdge <= syncSecond & ~levelLast; // Needs a low sample before a new edge
		end
	end

	always_ff @(posedge CLK) begin
		if (!RESETEDGE) begin
			playerPos <= LanePos'(PlayerStart);
			ammo <= '1;
			fireStrobe <= 1'b0;
		end else begin
			case ({pressEdge.left, pressEdge.right})
				2'b10: begin
					if (playerPos != '0) begin
						playerPos <= playerPos - 1'b1;
					end
				end
				2'b01: begin
					if (playerPos != LanePos'(LaneCount - 1)) begin
						playerPos <= playerPos + 1'b1;
					end
				end
				default: ; // Both or neither, stay put
			endcase
			fireStrobe <= shotOk;
			if (shotOk) begin
				ammo <= {ammo[AmmoMax-2:0], 1'b0}; // Spend one shot
			end
		end
	end

	posInField: assert property (@(posedge CLK) disable iff (!RESETEDGE)
		!(($past(playerPos) == '0 && playerPos == LanePos'(LaneCount - 1)) ||
		($past(playerPos) == LanePos'(LaneCount - 1) && playerPos == '0)))
		else $error("player wrapped past the field edge");

	ammoShape: assert property (@(posedge CLK) disable iff (!RESETEDGE) $onehot0(ammoGap))
		else $error("ammo is not a left-aligned thermometer");

	// Top bit of the thermometer marks a shot still in stock
	fireNeedsAmmo: assert property (@(posedge CLK) disable iff (!RESETEDGE)
		fireStrobe |-> $past(ammo[AmmoMax-1]))
		else $error("shot fired without ammo");
endmodule

//--- scoreKeeper.sv
`timescale 1ns/1ps
// Score tick counter, four-digit BCD score and game-over register
module scoreKeeper import dodgePkg::*; (
	input  logic                 CLK,
	input  logic                 RESETEDGE,
	input  logic [LaneCount-1:0] collide,
	output BcdScore              score,
	output logic                 gameOver
);
	logic [ScoreBits-1:0] tickCount;
	logic scoreTick;
	BcdScore scoreNext;
	logic scoreFull; // Carry out of the top digit

	assign scoreTick = tickCount == '1;

	// Decimal increment with ripple carry
	always_comb begin
		logic carry;
		carry = 1'b1;
		for (int d = 0; d < DigitCount; d++) begin
			if (carry && score[d] == 4'd9) begin
				scoreNext[d] = 4'd0;
			end else begin
				scoreNext[d] = score[d] + {3'b000, carry};
				carry = 1'b0;
			end
		end
		scoreFull = carry;
	end

	always_ff @(posedge CLK) begin
		if (!RESETEDGE) begin
			tickCount <= '0;
			score <= '0;
			gameOver <= 1'b0;
		end else begin
			tickCount <= tickCount + 1'b1;
			if (|collide) begin
				gameOver <= 1'b1;
			end
			if (scoreTick && !gameOver) begin
				if (scoreFull) begin
					gameOver <= 1'b1; // 9999 ends the game
				end else begin
					score <= scoreNext;
				end
			end
		end
	end

	for (genvar d = 0; d < DigitCount; d++) begin : digitCheck
		digitValid: assert property (@(posedge CLK) disable iff (!RESETEDGE)
			score[d] <= 4'd9)
			else $error("score digit %0d left the BCD range", d);
	end

	overHolds: assert property (@(posedge CLK) disable iff (!RESETEDGE)
		gameOver |=> gameOver && $stable(score))
		else $error("score or game over moved after the game ended");
endmodule

//--- sources.f
dodgePkg.sv
playerControl.sv
laneTimer.sv
obstacleLane.sv
scoreKeeper.sv
dodgeGame.sv
dodgeChecker.sv
tbDodgeGame.sv

//--- tbDodgeGame.sv
`timescale 1ns/1ps
// Testbench top for the dodge game with clock, reset, button stimulus and a cycle limit
module tbDodgeGame import dodgePkg::*; ();
	localparam int ResetCycles = 4;
	localparam int PressCycles = 12; // Worst case hold, settle and check of one press
	localparam int Presses = 21 + 7 + 2 + 3;
	localparam int ScorePeriods = 8;
	localparam int FrozenCycles = 2 * 64;
	localparam int CollideWait = 8 * 64; // Eight slowest lane steps
	localparam int CycleLimit = 3 * (4 * ResetCycles + Presses * PressCycles
		+ ScorePeriods * 32 + CollideWait + FrozenCycles + 6 * 2);

	logic CLK;
	logic RESETEDGE;
	Buttons buttons;
	GameView view;
	logic checkPoint;
	logic testEnd;
	int testId;
	int checkCount;
	int errorCount;
	int cycles;
	int bits;
	logic [31:0] lfsrState;

	dodgeGame dut (.CLK(CLK), .RESETEDGE(RESETEDGE), .buttons(buttons), .view(view));

	dodgeChecker viewCheck (.CLK(CLK), .RESETEDGE(RESETEDGE), .buttons(buttons), .view(view),
		.checkPoint(checkPoint), .testEnd(testEnd), .testId(testId),
		.checkCount(checkCount), .errorCount(errorCount));

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		return state[0] ? (state >> 1) ^ 32'h80200003 : state >> 1;
	endfunction

	task automatic takeBits(input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++) begin
			lfsrState = lfsrStep(lfsrState);
			value = (value << 1) | int'(lfsrState[0]);
		end
	endtask

	task automatic press(input logic left, input logic right, input logic fire);
		int holdCycles;
		takeBits(2, holdCycles);
		@(negedge CLK);
		buttons.left = left;
		buttons.right = right;
		buttons.fire = fire;
		repeat (holdCycles + 1) @(negedge CLK);
		buttons = '0;
		repeat (5) @(negedge CLK); // Sync pipeline settles
		checkPoint = 1'b1;
		@(negedge CLK);
		checkPoint = 1'b0;
	endtask

	task automatic applyReset(input logic check);
		@(negedge CLK);
		RESETEDGE = 1'b0;
		repeat (ResetCycles - 1) @(negedge CLK);
		checkPoint = check;
		@(negedge CLK);
		checkPoint = 1'b0;
		RESETEDGE = 1'b1;
	endtask

	task automatic finishTest();
		@(negedge CLK);
		testEnd = 1'b1;
		@(negedge CLK);
		testEnd = 1'b0;
	endtask

	initial begin
		cycles = 0;
		while (cycles < CycleLimit) begin
			@(posedge CLK);
			cycles++;
		end
		$display("run stopped after %0d cycles before the tests finished", cycles);
		$display("tests failed");
		$finish;
	end

	initial begin
		RESETEDGE = 1'b0;
		buttons = '0;
		checkPoint = 1'b0;
		testEnd = 1'b0;
		lfsrState = 32'h897ca05a;
		testId = 1;
		applyReset(1'b1);
		finishTest();
		testId = 2;
		repeat (5) press(1'b1, 1'b0, 1'b0); // Last one hits lane 0
		repeat (8) press(1'b0, 1'b1, 1'b0); // Last one hits lane 7
		repeat (8) begin
			takeBits(1, bits);
			press(bits == 0, bits == 1, 1'b0);
		end
		finishTest();
		testId = 3;
		applyReset(1'b0);
		repeat (7) press(1'b0, 1'b0, 1'b1); // Two more than the stock
		finishTest();
		testId = 4;
		applyReset(1'b0);
		repeat (ScorePeriods * 32) @(negedge CLK);
		finishTest();
		testId = 5;
		while (!view.gameOver) @(negedge CLK); // Player parked in lane 4
		press(1'b0, 1'b0, 1'b1);
		press(1'b1, 1'b0, 1'b0);
		repeat (FrozenCycles) @(negedge CLK);
		finishTest();
		testId = 6;
		press(1'b0, 1'b1, 1'b0);
		press(1'b0, 1'b0, 1'b1);
		applyReset(1'b1);
		finishTest();
		@(negedge CLK);
		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0 && checkCount > 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end
endmodule
